//--- verilog/spibus_pkg.sv
/* shared widths, command byte layout and idle read byte for the SPI register bridge.
   imported by the target, bridge, register bank and top level */
package spibus_pkg;

    typedef logic [3:0]  reg_num_t;             // one of sixteen registers
    typedef logic [7:0]  bus_byte_t;            // byte on the bus or the SPI wire
    typedef logic [15:0] reg_word_t;            // full register contents

    // command byte, all bits active high
    //  7  6  5  4  3  2  1  0
    // CS WR RS BS R3 R2 R1 R0
    localparam int CMD_CS_BIT  = 7;             // bus select
    localparam int CMD_WR_BIT  = 6;             // write, else read
    localparam int CMD_RS_BIT  = 5;             // soft reset request
    localparam int CMD_BS_BIT  = 4;             // byte select, 0 = high byte
    localparam int CMD_REG_LSB = 0;             // low bit of the register field

    localparam bus_byte_t IDLE_READ_BYTE = 8'hCB;   // sent back during a command byte

    typedef enum logic {
        wait_cmd,                               // next byte is a command
        wait_payload                            // next byte is the payload
    } bridge_state_t;

endpackage

//--- verilog/spi_target.sv
/* SPI mode 0 target, oversampled on pclk. shifts bytes in and out MSB first
   and hands the bridge single-cycle receive and transmit strobes */
module spi_target (
    input  logic                  pclk,
    input  logic                  rst_n_i,
    input  logic                  sck_i,          // SPI clock from controller
    input  logic                  cs_n_i,         // select, active low
    input  logic                  copi_i,         // controller out
    output logic                  cipo_o,         // controller in
    output logic                  select_o,       // synchronized select, active high
    output logic                  rx_strobe_o,    // byte received
    output logic                  tx_strobe_o,    // new byte frame, load tx_byte_i
    output spibus_pkg::bus_byte_t rx_byte_o,
    input  spibus_pkg::bus_byte_t tx_byte_i
);
    import spibus_pkg::*;

    logic [1:0] sck_sync;                       // two-flop synchronizers
    logic [1:0] cs_n_sync;
    logic [1:0] copi_sync;
    logic       sck_d;                          // previous synced sck
    logic       select_d;                       // previous synced select
    logic       sck_rise;
    logic       sck_fall;
    logic       sel_rise;                       // start of a select low period
    logic [2:0] bit_cnt;                        // bits received in this byte
    logic [6:0] rx_shift;                       // first seven bits of the byte
    bus_byte_t  tx_shift;                       // msb is on the wire

    assign select_o = ~cs_n_sync[1];
    assign sck_rise = sck_sync[1] & ~sck_d;
    assign sck_fall = ~sck_sync[1] & sck_d;
    assign sel_rise = select_o & ~select_d;
    assign cipo_o   = tx_shift[7];

    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            sck_sync    <= '0;
            cs_n_sync   <= '1;                  // idle deselected
            copi_sync   <= '0;
            sck_d       <= 1'b0;
            select_d    <= 1'b0;
            bit_cnt     <= '0;
            rx_strobe_o <= 1'b0;
            tx_strobe_o <= 1'b0;
            tx_shift    <= '0;                  // keeps cipo low out of reset
        end else begin
            sck_sync    <= {sck_sync[0], sck_i};
            cs_n_sync   <= {cs_n_sync[0], cs_n_i};
            copi_sync   <= {copi_sync[0], copi_i};
            sck_d       <= sck_sync[1];
            select_d    <= select_o;
            rx_strobe_o <= 1'b0;
            tx_strobe_o <= sel_rise;            // first frame of the packet
            if (!select_o) begin
                bit_cnt <= '0;                  // drop any partial byte
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_strobe_o <= 1'b1;
                    tx_strobe_o <= 1'b1;        // next frame follows at once
                end
            end
            if (tx_strobe_o) begin
                tx_shift <= tx_byte_i;
            end else if (select_o && sck_fall && bit_cnt != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0};  // no shift on the falling edge after bit 8
            end
        end
    end

    // receive data path
    always_ff @(posedge pclk) begin
        if (select_o && sck_rise) begin
            rx_shift <= {rx_shift[5:0], copi_sync[1]};
            if (bit_cnt == 3'd7) begin
                rx_byte_o <= {rx_shift, copi_sync[1]};
            end
        end
    end

endmodule

//--- verilog/spi_bus_bridge.sv
/* turns command and payload byte pairs from the SPI target into register bus
   accesses, and raises a soft reset pulse on request */
module spi_bus_bridge (
    input  logic                  pclk,
    input  logic                  rst_n_i,
    input  logic                  select_i,
    input  logic                  rx_strobe_i,
    input  logic                  tx_strobe_i,
    input  spibus_pkg::bus_byte_t rx_byte_i,
    output spibus_pkg::bus_byte_t tx_byte_o,
    output spibus_pkg::reg_num_t  bus_reg_num_o,
    output logic                  bus_bytesel_o,
    output logic                  bus_wr_strobe_o,
    output spibus_pkg::bus_byte_t bus_wr_data_o,
    input  spibus_pkg::bus_byte_t bus_rd_data_i,
    output logic                  soft_reset_o
);
    import spibus_pkg::*;

    bridge_state_t state;
    bridge_state_t state_d;
    bus_byte_t     cmd_q;                       // latched command byte
    bus_byte_t     cmd_now;                     // command seen by the bus this cycle
    logic          cmd_done;                    // command byte completes now

    assign cmd_done = select_i & rx_strobe_i & (state == wait_cmd);

    // the bus follows a finishing command at once, so the read byte is ready for tx_strobe
    assign cmd_now       = cmd_done ? rx_byte_i : cmd_q;
    assign bus_reg_num_o = cmd_now[CMD_REG_LSB +: $bits(reg_num_t)];
    assign bus_bytesel_o = cmd_now[CMD_BS_BIT];

    always_comb begin
        state_d = state;
        if (!select_i) begin
            state_d = wait_cmd;                 // deselect restarts the framing
        end else if (rx_strobe_i) begin
            state_d = (state == wait_cmd) ? wait_payload : wait_cmd;
        end
    end

    // register data for the payload frame, idle byte for a command frame
    assign tx_byte_o = (tx_strobe_i && state_d == wait_payload) ? bus_rd_data_i
                                                                : IDLE_READ_BYTE;

    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            state           <= wait_cmd;
            cmd_q           <= '0;
            bus_wr_strobe_o <= 1'b0;
            soft_reset_o    <= 1'b0;
        end else begin
            state           <= state_d;
            bus_wr_strobe_o <= 1'b0;
            soft_reset_o    <= 1'b0;
            if (cmd_done) begin
                cmd_q        <= rx_byte_i;
                soft_reset_o <= rx_byte_i[CMD_RS_BIT];
            end else if (select_i && rx_strobe_i) begin
                // payload done, write only when selected and writing
                bus_wr_strobe_o <= cmd_q[CMD_CS_BIT] & cmd_q[CMD_WR_BIT];
            end
        end
    end

    // payload byte, held for the write strobe
    always_ff @(posedge pclk) begin
        if (select_i && rx_strobe_i && state == wait_payload) begin
            bus_wr_data_o <= rx_byte_i;
        end
    end

endmodule

//--- verilog/reset_seq.sv
/* holds the core in reset until a delay counter saturates, restarted by the
   reset input or by a soft reset pulse */
module reset_seq #(
    parameter int unsigned RESET_CNT_W = 4      // delay is 2**RESET_CNT_W cycles
) (
    input  logic pclk,
    input  logic rst_n_i,
    input  logic soft_reset_i,
    output logic core_rst_o,                    // active high core reset
    output logic ready_o                        // core out of reset
);

    logic [RESET_CNT_W-1:0] reset_cnt;

    always_ff @(posedge pclk) begin
        if (!rst_n_i || soft_reset_i) begin
            reset_cnt  <= '0;
            core_rst_o <= 1'b1;
            ready_o    <= 1'b0;
        end else begin
            if (!(&reset_cnt)) begin
                reset_cnt <= reset_cnt + 1'b1;  // saturates at all ones
            end
            core_rst_o <= ~(&reset_cnt);
            ready_o    <= ~core_rst_o;
        end
    end

endmodule

//--- verilog/reg_bank.sv
/* sixteen 16-bit registers on a byte-wide bus. writes are byte selected,
   reads return the selected byte combinationally */
module reg_bank (
    input  logic                  pclk,
    input  logic                  core_rst_i,     // clears every register
    input  logic                  wr_strobe_i,
    input  logic                  bytesel_i,      // 0 = bits 15..8, 1 = bits 7..0
    input  spibus_pkg::reg_num_t  reg_num_i,
    input  spibus_pkg::bus_byte_t wr_data_i,
    output spibus_pkg::bus_byte_t rd_data_o
);
    import spibus_pkg::*;

    localparam int NUM_REGS = 2 ** $bits(reg_num_t);

    reg_word_t regs [NUM_REGS];
    reg_word_t rd_word;                         // addressed register

    always_ff @(posedge pclk) begin
        if (core_rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_strobe_i) begin
            if (bytesel_i) begin
                regs[reg_num_i][7:0]  <= wr_data_i;     // low byte
            end else begin
                regs[reg_num_i][15:8] <= wr_data_i;     // high byte
            end
        end
    end

    // read mux
    assign rd_word   = regs[reg_num_i];
    assign rd_data_o = bytesel_i ? rd_word[7:0] : rd_word[15:8];

endmodule

//--- verilog/spibus_top.sv
/* top level of the SPI register bridge. connects the SPI target, the bridge,
   the reset sequencer and the register bank */
module spibus_top #(
    parameter int unsigned RESET_CNT_W = 4      // reset delay counter width
) (
    input  logic pclk,
    input  logic rst_n_i,                       // board reset, active low
    input  logic sck_i,
    input  logic cs_n_i,
    input  logic copi_i,
    output logic cipo_o,
    output logic ready_o                        // core out of reset
);
    import spibus_pkg::*;

    logic      spi_select;
    logic      rx_strobe;
    logic      tx_strobe;
    bus_byte_t rx_byte;
    bus_byte_t tx_byte;
    reg_num_t  bus_reg_num;
    logic      bus_bytesel;
    logic      bus_wr_strobe;
    bus_byte_t bus_wr_data;
    bus_byte_t bus_rd_data;
    logic      soft_reset;                      // from an RS command bit
    logic      core_rst;

    spi_target spi_target_i (
        .pclk        (pclk),
        .rst_n_i     (rst_n_i),
        .sck_i       (sck_i),
        .cs_n_i      (cs_n_i),
        .copi_i      (copi_i),
        .cipo_o      (cipo_o),
        .select_o    (spi_select),
        .rx_strobe_o (rx_strobe),
        .tx_strobe_o (tx_strobe),
        .rx_byte_o   (rx_byte),
        .tx_byte_i   (tx_byte)
    );

    spi_bus_bridge spi_bus_bridge_i (
        .pclk            (pclk),
        .rst_n_i         (rst_n_i),
        .select_i        (spi_select),
        .rx_strobe_i     (rx_strobe),
        .tx_strobe_i     (tx_strobe),
        .rx_byte_i       (rx_byte),
        .tx_byte_o       (tx_byte),
        .bus_reg_num_o   (bus_reg_num),
        .bus_bytesel_o   (bus_bytesel),
        .bus_wr_strobe_o (bus_wr_strobe),
        .bus_wr_data_o   (bus_wr_data),
        .bus_rd_data_i   (bus_rd_data),
        .soft_reset_o    (soft_reset)
    );

    reset_seq #(
        .RESET_CNT_W (RESET_CNT_W)
    ) reset_seq_i (
        .pclk         (pclk),
        .rst_n_i      (rst_n_i),
        .soft_reset_i (soft_reset),
        .core_rst_o   (core_rst),
        .ready_o      (ready_o)
    );

    reg_bank reg_bank_i (
        .pclk        (pclk),
        .core_rst_i  (core_rst),
        .wr_strobe_i (bus_wr_strobe),
        .bytesel_i   (bus_bytesel),
        .reg_num_i   (bus_reg_num),
        .wr_data_i   (bus_wr_data),
        .rd_data_o   (bus_rd_data)
    );

endmodule

//--- tests/tb_spibus.sv
/* testbench for the SPI register bridge. sends seeded random SPI packets to the
   top level and checks every returned byte against a register model */
module tb_spibus;
    timeunit 1ns;
    timeprecision 1ps;

    import spibus_pkg::*;

    localparam int NUM_PACKETS = 271;           // packets in the whole run including the aborted frame
    localparam int CYCLE_LIMIT = 3 * NUM_PACKETS * 16 * 8 + 1000;
    localparam int HALF_SCK    = 4;             // pclk cycles per sck phase

    logic pclk;
    logic rst_n;
    logic sck;
    logic cs_n;
    logic copi;
    logic cipo;
    logic ready;

    reg_word_t model_regs [16];                 // expected register contents
    int        cycle_cnt   = 0;
    int        ready_falls = 0;                 // falling edges seen on ready_o
    logic      ready_prev;

    spibus_top #(
        .RESET_CNT_W (4)
    ) dut_i (
        .pclk    (pclk),
        .rst_n_i (rst_n),
        .sck_i   (sck),
        .cs_n_i  (cs_n),
        .copi_i  (copi),
        .cipo_o  (cipo),
        .ready_o (ready)
    );

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;               // 100 ns period
    end

    // watchdog
    always @(posedge pclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // counts drops of ready_o so that a soft reset can be seen
    always @(posedge pclk) begin
        if (ready_prev === 1'b1 && ready === 1'b0) begin
            ready_falls <= ready_falls + 1;
        end
        ready_prev <= ready;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge pclk);
        #10;                                    // drive slot after the edge
    endtask

    task automatic check_byte(input bus_byte_t actual, input bus_byte_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERR at %0d ns: %s is %02h, expected %02h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_ready(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("ERR at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic wait_ready(input int bound);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < bound) begin
            wait_cycles(1);
            n++;
        end
        if (ready !== 1'b1) begin
            $display("ready_o did not rise within %0d clock cycles", bound);
            $display("TEST FAIL");
            $fatal(1, "core never left reset");
        end
    endtask

    // mode 0 msb first with one bit per 2*HALF_SCK cycles
    task automatic spi_shift(input bus_byte_t tx, input int nbits, output bus_byte_t rx);
        rx = '0;
        for (int i = 7; i > 7 - nbits; i--) begin
            copi = tx[i];
            wait_cycles(HALF_SCK);
            rx[i] = cipo;                       // sampled ahead of the rising edge
            sck = 1'b1;
            wait_cycles(HALF_SCK);
            sck = 1'b0;
        end
    endtask

    task automatic spi_packet(input bus_byte_t cmd, input bus_byte_t payload,
                              output bus_byte_t cmd_rx, output bus_byte_t payload_rx);
        cs_n = 1'b0;
        wait_cycles(8);                         // target loads the first frame
        spi_shift(cmd, 8, cmd_rx);
        spi_shift(payload, 8, payload_rx);
        wait_cycles(8);                         // let the bus write land
        cs_n = 1'b1;
        copi = 1'b0;
        wait_cycles(8);
    endtask

    function automatic bus_byte_t make_cmd(input logic cs, input logic wr, input logic rs,
                                           input logic bs, input reg_num_t r);
        bus_byte_t cmd;
        cmd = '0;
        cmd[CMD_CS_BIT] = cs;
        cmd[CMD_WR_BIT] = wr;
        cmd[CMD_RS_BIT] = rs;
        cmd[CMD_BS_BIT] = bs;
        cmd[CMD_REG_LSB +: $bits(reg_num_t)] = r;
        return cmd;
    endfunction

    function automatic bus_byte_t model_read(input reg_num_t r, input logic bs);
        return bs ? model_regs[r][7:0] : model_regs[r][15:8];   // 1 = low byte
    endfunction

    task automatic clear_model();
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
    endtask

    // one checked packet after which the model follows the command
    task automatic bus_access(input logic cs, input logic wr, input logic rs, input logic bs,
                              input reg_num_t r, input bus_byte_t payload);
        bus_byte_t cmd_rx;
        bus_byte_t data_rx;
        bus_byte_t expected;

        expected = model_read(r, bs);           // value at the end of the command byte
        spi_packet(make_cmd(cs, wr, rs, bs, r), payload, cmd_rx, data_rx);
        check_byte(cmd_rx, IDLE_READ_BYTE, "command frame byte");
        check_byte(data_rx, expected, "payload frame byte");
        if (cs && wr) begin
            if (bs) begin
                model_regs[r][7:0] = payload;
            end else begin
                model_regs[r][15:8] = payload;
            end
        end
        if (rs) begin
            clear_model();
        end
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < 16; i++) begin
            bus_access(1'b1, 1'b0, 1'b0, 1'b0, reg_num_t'(i), 8'h00);
            bus_access(1'b1, 1'b0, 1'b0, 1'b1, reg_num_t'(i), 8'h00);
        end
    endtask

    initial begin
        int unsigned rnd;
        reg_num_t    r;
        logic        bs;
        bus_byte_t   val;
        bus_byte_t   part_rx;
        int          falls_before;

        rst_n = 1'b0;
        sck   = 1'b0;                           // mode 0 idle level
        cs_n  = 1'b1;
        copi  = 1'b0;
        clear_model();
        void'($urandom(32'hcf10));

        wait_cycles(4);
        check_ready(ready, 1'b0, "ready_o during reset");
        check_byte({7'd0, cipo}, 8'h00, "cipo_o during reset");
        rst_n = 1'b1;
        wait_ready(20);
        read_all_regs();                        // everything starts at zero

        // random reads and writes with select always set
        repeat (200) begin
            rnd = $urandom();
            bus_access(1'b1, rnd[5], 1'b0, rnd[4], rnd[3:0], rnd[15:8]);
        end

        // write bit without select must not reach the register
        rnd = $urandom();
        r   = rnd[3:0];
        bs  = rnd[4];
        val = rnd[15:8];
        bus_access(1'b1, 1'b1, 1'b0, bs, r, val);
        bus_access(1'b0, 1'b1, 1'b0, bs, r, ~val);
        bus_access(1'b1, 1'b0, 1'b0, bs, r, 8'h00);

        // soft reset drops ready and clears the bank
        falls_before = ready_falls;
        bus_access(1'b0, 1'b0, 1'b1, 1'b0, 4'd0, 8'h00);
        wait_ready(40);
        check_ready(ready_falls != falls_before, 1'b1, "ready_o drop after soft reset");
        read_all_regs();

        // abort a command after four bits so the framing restarts
        cs_n = 1'b0;
        wait_cycles(8);
        spi_shift(8'hC3, 4, part_rx);
        check_byte(part_rx & 8'hF0, IDLE_READ_BYTE & 8'hF0, "aborted frame bits");
        wait_cycles(HALF_SCK);
        cs_n = 1'b1;
        wait_cycles(8);
        rnd = $urandom();
        bus_access(1'b1, 1'b1, 1'b0, rnd[4], rnd[3:0], rnd[15:8]);
        bus_access(1'b1, 1'b0, 1'b0, rnd[4], rnd[3:0], 8'h00);

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- project.f
verilog/spibus_pkg.sv
verilog/spi_target.sv
verilog/spi_bus_bridge.sv
verilog/reset_seq.sv
verilog/reg_bank.sv
verilog/spibus_top.sv
tests/tb_spibus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the SPI register bridge testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_spibus -f project.f -o tb_spibus

# a failed check ends the run with a non-zero status, the log is searched below
./obj_dir/tb_spibus > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"
